/* rtl/cpu_defines.svh */
// shared width, reset and encoding macros for the two-stage rv64 core
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath and address width, rv64
`define CPU_XLEN 64

// every instruction is one 32-bit word, no compressed encodings
`define CPU_ILEN 32

// register index width, 32 integer registers
`define CPU_REG_ADDR_W 5

// program counter after reset
`define CPU_RESET_PC 64'h0000_0000_0000_0000

// addi x0, x0, 0
// the fetch register holds this after reset so the first execute cycle does nothing
`define CPU_NOP_INSTR 32'h0000_0013

// default pc step and jal link offset
`define CPU_INSTR_BYTES 4

`endif

/* rtl/cpu_pkg.sv */
// types shared between fetch, decode, register file and execute
`include "cpu_defines.svh"

package cpu_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_OP_IMM = 7'b0010011,  // addi only
        OPC_OP     = 7'b0110011,  // add, sub
        OPC_LOAD   = 7'b0000011,  // lb, ld
        OPC_STORE  = 7'b0100011,  // sd
        OPC_BRANCH = 7'b1100011,  // beq, bne
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [1:0] {
        ALU_ADD    = 2'b00,  // rs1 + operand b
        ALU_SUB    = 2'b01,  // rs1 - operand b
        ALU_PASS_B = 2'b10,  // lui result is the immediate itself
        ALU_ADD_PC = 2'b11   // auipc and jal link
    } alu_op_e;

    typedef enum logic {
        MEM_BYTE   = 1'b0,
        MEM_DOUBLE = 1'b1
    } mem_size_e;

    typedef enum logic [1:0] {
        BR_NONE = 2'b00,
        BR_EQ   = 2'b01,
        BR_NE   = 2'b10,
        BR_JUMP = 2'b11  // unconditional
    } branch_e;

    // fetch register contents
    typedef struct packed {
        logic                   valid;  // low means bubble
        logic [`CPU_XLEN-1:0]   pc;
        logic [`CPU_ILEN-1:0]   instr;
    } fetch_packet_t;

    typedef struct packed {
        logic [`CPU_REG_ADDR_W-1:0] rd;
        logic [`CPU_REG_ADDR_W-1:0] rs1;
        logic [`CPU_REG_ADDR_W-1:0] rs2;
        logic [`CPU_XLEN-1:0]       imm;  // already sign extended
        alu_op_e                    alu_op;
        logic                       use_imm;
        logic                       reg_write;
        logic                       mem_read;
        logic                       mem_write;
        mem_size_e                  mem_size;
        branch_e                    branch;
    } decoded_instr_t;

    typedef struct packed {
        logic                       en;
        logic [`CPU_REG_ADDR_W-1:0] addr;
        logic [`CPU_XLEN-1:0]       data;
    } writeback_t;

    typedef struct packed {
        logic                 valid;
        logic [`CPU_XLEN-1:0] target;
    } redirect_t;

endpackage

/* rtl/fetch_stage.sv */
// fetch stage holding the program counter and the fetch register, flushed on redirect
`timescale 1ns/100ps
`include "cpu_defines.svh"

module fetch_stage (
    input  logic                    i_clk_1hz,
    input  logic                    i_reset_n,
    input  cpu_pkg::redirect_t      i_redirect,   // taken branch or jal from execute
    input  logic [`CPU_ILEN-1:0]    i_imem_data,  // instruction at o_imem_addr, same cycle
    output logic [`CPU_XLEN-1:0]    o_imem_addr,
    output cpu_pkg::fetch_packet_t  o_fetch
);

    logic [`CPU_XLEN-1:0] pc_q;
    logic [`CPU_XLEN-1:0] pc_next;

    assign o_imem_addr = pc_q;  // memory answers combinationally

    // redirect wins over the default step
    always_comb begin
        if (i_redirect.valid) begin
            pc_next = i_redirect.target;
        end else begin
            pc_next = pc_q + `CPU_XLEN'(`CPU_INSTR_BYTES);
        end
    end

    always_ff @(posedge i_clk_1hz or negedge i_reset_n) begin
        if (!i_reset_n) begin
            pc_q          <= `CPU_RESET_PC;
            o_fetch.valid <= 1'b0;
            o_fetch.pc    <= `CPU_RESET_PC;
            o_fetch.instr <= `CPU_NOP_INSTR;  // nop until the first real capture
        end else begin
            pc_q <= pc_next;
            // the word fetched alongside a taken branch is on the wrong path
            // so it is captured as a bubble
            o_fetch.valid <= !i_redirect.valid;
            o_fetch.pc    <= pc_q;
            o_fetch.instr <= i_imem_data;
        end
    end

endmodule

/* rtl/instr_decoder.sv */
// instruction decoder producing register indices, immediates and control fields
`timescale 1ns/100ps
`include "cpu_defines.svh"

module instr_decoder (
    input  cpu_pkg::fetch_packet_t   i_fetch,
    output cpu_pkg::decoded_instr_t  o_decoded
);

    import cpu_pkg::*;

    logic [`CPU_ILEN-1:0] instr;
    opcode_e              opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic [`CPU_XLEN-1:0] imm_i;
    logic [`CPU_XLEN-1:0] imm_s;
    logic [`CPU_XLEN-1:0] imm_b;
    logic [`CPU_XLEN-1:0] imm_u;
    logic [`CPU_XLEN-1:0] imm_j;

    assign instr  = i_fetch.instr;
    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // immediate formats, all sign extended from instr[31]
    assign imm_i = {{(`CPU_XLEN-12){instr[31]}}, instr[31:20]};               // addi, loads
    assign imm_s = {{(`CPU_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};  // stores
    assign imm_b = {{(`CPU_XLEN-13){instr[31]}}, instr[31], instr[7],
                    instr[30:25], instr[11:8], 1'b0};                         // branches, bit 0 is zero
    assign imm_u = {{(`CPU_XLEN-32){instr[31]}}, instr[31:12], 12'b0};        // lui, auipc
    assign imm_j = {{(`CPU_XLEN-21){instr[31]}}, instr[31], instr[19:12],
                    instr[20], instr[30:21], 1'b0};                           // jal

    always_comb begin
        // everything inactive unless a supported encoding matches
        o_decoded           = '0;
        o_decoded.rd        = instr[11:7];
        o_decoded.rs1       = instr[19:15];
        o_decoded.rs2       = instr[24:20];
        o_decoded.imm       = imm_i;
        o_decoded.alu_op    = ALU_ADD;
        o_decoded.mem_size  = MEM_DOUBLE;
        o_decoded.branch    = BR_NONE;

        if (i_fetch.valid) begin  // bubbles decode as nop
            case (opcode)
                OPC_LUI: begin
                    o_decoded.imm       = imm_u;
                    o_decoded.alu_op    = ALU_PASS_B;
                    o_decoded.use_imm   = 1'b1;
                    o_decoded.reg_write = 1'b1;
                end
                OPC_AUIPC: begin
                    o_decoded.imm       = imm_u;
                    o_decoded.alu_op    = ALU_ADD_PC;  // pc of this instruction + imm
                    o_decoded.use_imm   = 1'b1;
                    o_decoded.reg_write = 1'b1;
                end
                OPC_OP_IMM: begin
                    if (funct3 == 3'b000) begin  // addi
                        o_decoded.use_imm   = 1'b1;
                        o_decoded.reg_write = 1'b1;
                    end
                end
                OPC_OP: begin
                    if (funct3 == 3'b000 && funct7 == 7'b0000000) begin  // add
                        o_decoded.reg_write = 1'b1;
                    end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
                        o_decoded.alu_op    = ALU_SUB;
                        o_decoded.reg_write = 1'b1;
                    end
                end
                OPC_LOAD: begin
                    // address is rs1 + imm_i through the alu
                    if (funct3 == 3'b000 || funct3 == 3'b011) begin
                        o_decoded.use_imm   = 1'b1;
                        o_decoded.reg_write = 1'b1;
                        o_decoded.mem_read  = 1'b1;
                        o_decoded.mem_size  = (funct3 == 3'b000) ? MEM_BYTE : MEM_DOUBLE;
                    end
                end
                OPC_STORE: begin
                    if (funct3 == 3'b011) begin  // sd only
                        o_decoded.imm       = imm_s;
                        o_decoded.use_imm   = 1'b1;
                        o_decoded.mem_write = 1'b1;
                    end
                end
                OPC_BRANCH: begin
                    o_decoded.imm = imm_b;
                    if (funct3 == 3'b000) begin
                        o_decoded.branch = BR_EQ;
                    end else if (funct3 == 3'b001) begin
                        o_decoded.branch = BR_NE;
                    end
                end
                OPC_JAL: begin
                    o_decoded.imm       = imm_j;
                    o_decoded.alu_op    = ALU_ADD_PC;  // link = pc + 4
                    o_decoded.reg_write = 1'b1;
                    o_decoded.branch    = BR_JUMP;
                end
                default: ;  // unsupported opcode stays a nop
            endcase
        end
    end

endmodule

/* rtl/register_file.sv */
// 32 x 64-bit integer register file with two async read ports and x0 tied to zero
`timescale 1ns/100ps
`include "cpu_defines.svh"

module register_file (
    input  logic                         i_clk_1hz,
    input  logic                         i_reset_n,
    input  logic [`CPU_REG_ADDR_W-1:0]   i_rs1_addr,
    input  logic [`CPU_REG_ADDR_W-1:0]   i_rs2_addr,
    output logic [`CPU_XLEN-1:0]         o_rs1_data,
    output logic [`CPU_XLEN-1:0]         o_rs2_data,
    input  cpu_pkg::writeback_t          i_writeback
);

    localparam int NUM_REGS = 1 << `CPU_REG_ADDR_W;

    logic [`CPU_XLEN-1:0] regs [NUM_REGS];

    // reads are combinational, x0 never leaves zero
    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

    // write lands at the end of the execute cycle
    // so the next instruction already sees it
    always_ff @(posedge i_clk_1hz or negedge i_reset_n) begin
        if (!i_reset_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_writeback.en && i_writeback.addr != '0) begin  // drop writes to x0
            regs[i_writeback.addr] <= i_writeback.data;
        end
    end

endmodule

/* rtl/execute_stage.sv */
// execute stage with alu, branch compare, memory request, load extension and writeback
`timescale 1ns/100ps
`include "cpu_defines.svh"

module execute_stage (
    input  cpu_pkg::fetch_packet_t   i_fetch,
    input  cpu_pkg::decoded_instr_t  i_decoded,
    input  logic [`CPU_XLEN-1:0]     i_rs1_data,
    input  logic [`CPU_XLEN-1:0]     i_rs2_data,
    input  logic [`CPU_XLEN-1:0]     i_dmem_rdata,  // read data for o_dmem_addr, same cycle
    output logic [`CPU_XLEN-1:0]     o_dmem_addr,
    output logic [`CPU_XLEN-1:0]     o_dmem_wdata,
    output logic                     o_dmem_we,
    output cpu_pkg::writeback_t      o_writeback,
    output cpu_pkg::redirect_t       o_redirect
);

    import cpu_pkg::*;

    logic [`CPU_XLEN-1:0] op_b;
    logic [`CPU_XLEN-1:0] alu_result;
    logic [`CPU_XLEN-1:0] load_data;
    logic [`CPU_XLEN-1:0] branch_target;
    logic                 branch_taken;

    // second operand
    // jal uses the instruction size so the add-pc path gives the link address
    always_comb begin
        if (i_decoded.branch == BR_JUMP) begin
            op_b = `CPU_XLEN'(`CPU_INSTR_BYTES);
        end else if (i_decoded.use_imm) begin
            op_b = i_decoded.imm;
        end else begin
            op_b = i_rs2_data;
        end
    end

    always_comb begin
        case (i_decoded.alu_op)
            ALU_ADD:    alu_result = i_rs1_data + op_b;  // add, addi, load/store address
            ALU_SUB:    alu_result = i_rs1_data - op_b;
            ALU_PASS_B: alu_result = op_b;               // lui
            ALU_ADD_PC: alu_result = i_fetch.pc + op_b;  // auipc or jal link
            default:    alu_result = i_rs1_data + op_b;
        endcase
    end

    // data memory request, addressed by rs1 + imm
    assign o_dmem_addr  = alu_result;
    assign o_dmem_wdata = i_rs2_data;       // sd stores all 64 bits of rs2
    assign o_dmem_we    = i_decoded.mem_write;  // one-cycle strobe, decoder clears it for bubbles

    // lb sign extends the addressed byte, ld takes the whole word
    always_comb begin
        case (i_decoded.mem_size)
            MEM_BYTE:   load_data = {{(`CPU_XLEN-8){i_dmem_rdata[7]}}, i_dmem_rdata[7:0]};
            MEM_DOUBLE: load_data = i_dmem_rdata;
            default:    load_data = i_dmem_rdata;
        endcase
    end

    always_comb begin
        o_writeback.en   = i_decoded.reg_write;
        o_writeback.addr = i_decoded.rd;
        o_writeback.data = i_decoded.mem_read ? load_data : alu_result;
    end

    // branch and jump targets are both pc-relative
    assign branch_target = i_fetch.pc + i_decoded.imm;

    always_comb begin
        case (i_decoded.branch)
            BR_EQ:   branch_taken = (i_rs1_data == i_rs2_data);
            BR_NE:   branch_taken = (i_rs1_data != i_rs2_data);
            BR_JUMP: branch_taken = 1'b1;
            default: branch_taken = 1'b0;  // not a control-flow instruction
        endcase
    end

    // a taken redirect makes fetch drop the word it is capturing
    // which gives the one-cycle bubble
    always_comb begin
        o_redirect.valid  = branch_taken;
        o_redirect.target = branch_target;
    end

endmodule

/* rtl/cpu_top.sv */
// two-stage rv64 core top level tying fetch, decode, register file and execute together
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpu_top (
    input  logic                  i_clk_1hz,
    input  logic                  i_reset_n,
    // instruction port, answered in the same cycle
    output logic [`CPU_XLEN-1:0]  o_imem_addr,
    input  logic [`CPU_ILEN-1:0]  i_imem_data,
    // data port, write strobe lasts one cycle
    output logic [`CPU_XLEN-1:0]  o_dmem_addr,
    output logic [`CPU_XLEN-1:0]  o_dmem_wdata,
    output logic                  o_dmem_we,
    input  logic [`CPU_XLEN-1:0]  i_dmem_rdata
);

    import cpu_pkg::*;

    fetch_packet_t        fetch;      // fetch register, read during execute
    decoded_instr_t       decoded;
    writeback_t           writeback;
    redirect_t            redirect;   // execute back to fetch
    logic [`CPU_XLEN-1:0] rs1_data;
    logic [`CPU_XLEN-1:0] rs2_data;

    fetch_stage u_fetch (
        .i_clk_1hz   (i_clk_1hz),
        .i_reset_n   (i_reset_n),
        .i_redirect  (redirect),
        .i_imem_data (i_imem_data),
        .o_imem_addr (o_imem_addr),
        .o_fetch     (fetch)
    );

    instr_decoder u_decoder (
        .i_fetch   (fetch),
        .o_decoded (decoded)
    );

    register_file u_regfile (
        .i_clk_1hz   (i_clk_1hz),
        .i_reset_n   (i_reset_n),
        .i_rs1_addr  (decoded.rs1),
        .i_rs2_addr  (decoded.rs2),
        .o_rs1_data  (rs1_data),
        .o_rs2_data  (rs2_data),
        .i_writeback (writeback)
    );

    execute_stage u_execute (
        .i_fetch      (fetch),
        .i_decoded    (decoded),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .i_dmem_rdata (i_dmem_rdata),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .o_dmem_we    (o_dmem_we),
        .o_writeback  (writeback),
        .o_redirect   (redirect)
    );

endmodule

/* verification/tb_program.svh */
// test program for the two-stage core with the store results it must produce
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int PROG_LEN   = 25;
localparam int NUM_STORES = 10;

// pc of the final jal x0, 0
localparam logic [63:0] LOOP_PC = 64'h60;

localparam logic [31:0] PROG [PROG_LEN] = '{
    32'h123450B7, 32'h08103023,  // 00 lui x1, 0x12345      04 sd x1, 0x80(x0)
    32'h00001117, 32'h08203423,  // 08 auipc x2, 0x1        0c sd x2, 0x88(x0)
    32'h67808193, 32'h08303823,  // 10 addi x3, x1, 0x678   14 sd x3, 0x90(x0)
    32'hFFB00213, 32'h004182B3,  // 18 addi x4, x0, -5      1c add x5, x3, x4
    32'h08503C23, 32'h40320333,  // 20 sd x5, 0x98(x0)      24 sub x6, x4, x3
    32'h0A603023, 32'h04000383,  // 28 sd x6, 0xa0(x0)      2c lb x7, 0x40(x0)
    32'h0A703423, 32'h04803403,  // 30 sd x7, 0xa8(x0)      34 ld x8, 0x48(x0)
    32'h0A803823, 32'h00318463,  // 38 sd x8, 0xb0(x0)      3c beq x3, x3, +8
    32'h0E103C23, 32'h00001463,  // 40 sd x1, 0xf8 skipped  44 bne x0, x0, +8
    32'h0A303C23, 32'h05500013,  // 48 sd x3, 0xb8(x0)      4c addi x0, x0, 0x55
    32'h0C003023, 32'h008004EF,  // 50 sd x0, 0xc0(x0)      54 jal x9, +8
    32'h0E103823, 32'h0C903423,  // 58 sd x1, 0xf0 skipped  5c sd x9, 0xc8(x0)
    32'h0000006F                 // 60 jal x0, 0
};

// addresses of the stores on the skipped paths
localparam logic [63:0] MARKER_BEQ = 64'hF8;
localparam logic [63:0] MARKER_JAL = 64'hF0;

localparam logic [63:0] STORE_ADDR [NUM_STORES] = '{
    64'h80, 64'h88, 64'h90, 64'h98, 64'hA0, 64'hA8, 64'hB0, 64'hB8, 64'hC0, 64'hC8
};
localparam logic [63:0] STORE_PC [NUM_STORES] = '{
    64'h04, 64'h0C, 64'h14, 64'h20, 64'h28, 64'h30, 64'h38, 64'h48, 64'h50, 64'h5C
};

localparam logic [63:0] X1_VAL = 64'h12345 << 12;            // lui
localparam logic [63:0] X3_VAL = X1_VAL + 64'h678;           // addi
localparam logic [63:0] X4_VAL = 64'hFFFF_FFFF_FFFF_FFFB;    // -5

`endif

/* verification/cpu_tb.sv */
// testbench for the two-stage rv64 core with memory models and store checks
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpu_tb;

    `include "tb_program.svh"

    localparam int WATCHDOG_CYCLES = PROG_LEN * 10 * 2;

    logic                 clk_1hz;
    logic                 reset_n;
    logic [`CPU_XLEN-1:0] imem_addr;
    logic [`CPU_ILEN-1:0] imem_data;
    logic [`CPU_XLEN-1:0] dmem_addr;
    logic [`CPU_XLEN-1:0] dmem_wdata;
    logic                 dmem_we;
    logic [`CPU_XLEN-1:0] dmem_rdata;

    logic [7:0]           dmem [256];  // byte wide, wraps on addr[7:0]
    int                   store_count;
    int                   loop_cycles;
    logic                 first_cycle;  // first edge after reset release
    logic [`CPU_XLEN-1:0] prev_imem_addr;

    cpu_top uut (
        .i_clk_1hz    (clk_1hz),
        .i_reset_n    (reset_n),
        .o_imem_addr  (imem_addr),
        .i_imem_data  (imem_data),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_wdata (dmem_wdata),
        .o_dmem_we    (dmem_we),
        .i_dmem_rdata (dmem_rdata)
    );

    initial clk_1hz = 1'b0;
    always #5 clk_1hz = ~clk_1hz;

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("Some tests failed");
        $display("FAIL %s expected %h actual %h", name, exp, act);
        $fatal(1, "stopping on value mismatch");
    endtask

    task automatic report_error(input string what);
        $display("Some tests failed");
        $display("%s", what);
        $fatal(1, "stopping on error");
    endtask

    // preload pattern, every byte differs with its address
    function automatic logic [7:0] fill_byte(input logic [7:0] a);
        return a ^ 8'hA5;
    endfunction

    function automatic logic [63:0] lb_expected();
        logic [7:0] b;
        b = fill_byte(8'h40);
        return {{56{b[7]}}, b};  // 0x40 ^ 0xa5 has bit 7 set
    endfunction

    function automatic logic [63:0] ld_expected();
        logic [63:0] d;
        d = '0;
        for (int k = 7; k >= 0; k--) begin
            d = {d[55:0], fill_byte(8'(8'h48 + k))};  // little endian
        end
        return d;
    endfunction

    function automatic logic [63:0] expected_store_data(input int idx);
        case (idx)
            0:       return X1_VAL;
            1:       return 64'h08 + (64'h1 << 12);  // auipc at pc 0x08
            2:       return X3_VAL;
            3:       return X3_VAL + X4_VAL;          // add
            4:       return X4_VAL - X3_VAL;          // sub
            5:       return lb_expected();
            6:       return ld_expected();
            7:       return X3_VAL;                   // after the not-taken bne
            8:       return 64'h0;                    // x0 after addi into x0
            default: return 64'h54 + 64'd4;          // jal link
        endcase
    endfunction

    // instruction memory, answers in the same cycle
    always_comb begin
        if (imem_addr < 64'(PROG_LEN * 4)) begin
            imem_data = PROG[imem_addr[6:2]];
        end else begin
            imem_data = `CPU_NOP_INSTR;  // past the end of the program
        end
    end

    // data memory read, eight bytes from the request address
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            dmem_rdata[k*8 +: 8] = dmem[8'(dmem_addr[7:0] + 8'(k))];
        end
    end

    // data memory write and the store log checks
    always @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            for (int a = 0; a < 256; a++) begin
                dmem[a] <= fill_byte(8'(a));
            end
        end else if (dmem_we) begin
            assert (dmem_addr != MARKER_BEQ && dmem_addr != MARKER_JAL)
                else report_error("a store on a skipped path reached memory");
            assert (store_count < NUM_STORES)
                else report_error("more stores than the program issues");
            assert (dmem_addr == STORE_ADDR[store_count])
                else report_mismatch("store_order_addr", STORE_ADDR[store_count], dmem_addr);
            assert (dmem_wdata == expected_store_data(store_count))
                else report_mismatch("store_data", expected_store_data(store_count),
                                     dmem_wdata);
            assert (prev_imem_addr == STORE_PC[store_count])  // two edges after fetch
                else report_mismatch("store_latency_pc", STORE_PC[store_count],
                                     prev_imem_addr);
            for (int k = 0; k < 8; k++) begin
                dmem[8'(dmem_addr[7:0] + 8'(k))] <= dmem_wdata[k*8 +: 8];
            end
            store_count <= store_count + 1;
        end
    end

    // reset state, pc history and self-loop detection
    always @(posedge clk_1hz) begin
        if (!reset_n || first_cycle) begin
            assert (dmem_we == 1'b0)
                else report_mismatch("reset_dmem_we", 64'h0, 64'(dmem_we));
            assert (imem_addr == `CPU_RESET_PC)
                else report_mismatch("reset_pc", `CPU_RESET_PC, imem_addr);
        end
        first_cycle = !reset_n;
        // the self-jump alternates the loop pc and the bubble fetch behind it
        if (reset_n && (imem_addr == LOOP_PC || imem_addr == LOOP_PC + 64'd4)) begin
            loop_cycles = loop_cycles + 1;
        end else begin
            loop_cycles = 0;
        end
        prev_imem_addr <= imem_addr;  // fetch address of the instruction now executing
    end

    // the fetch after a taken branch or jal is its target
    assert property (@(posedge clk_1hz) disable iff (!reset_n)
        (imem_addr == 64'h40) |=> (imem_addr == 64'h44))
        else report_error("beq did not redirect fetch to its target");
    assert property (@(posedge clk_1hz) disable iff (!reset_n)
        (imem_addr == 64'h58) |=> (imem_addr == 64'h5C))
        else report_error("jal did not redirect fetch to its target");

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * 10);
        report_error("watchdog timeout, program never reached its final loop");
    end

    initial begin
        reset_n        = 1'b0;
        store_count    = 0;
        loop_cycles    = 0;
        first_cycle    = 1'b0;
        prev_imem_addr = '0;
        repeat (3) @(posedge clk_1hz);
        @(negedge clk_1hz);
        reset_n = 1'b1;
        // two turns of the final self-jump
        while (loop_cycles < 4) begin
            @(negedge clk_1hz);
        end
        if (store_count == NUM_STORES) begin
            $display("All tests passed");
            $finish;
        end else begin
            report_mismatch("store_count", 64'(NUM_STORES), 64'(store_count));
        end
    end

endmodule

/* verilog.f */
+incdir+rtl
+incdir+verification
rtl/cpu_pkg.sv
rtl/fetch_stage.sv
rtl/instr_decoder.sv
rtl/register_file.sv
rtl/execute_stage.sv
rtl/cpu_top.sv
verification/cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the core testbench with Verilator, exit status reports the result
cd "$(dirname "$0")" && \
verilator --binary --timing --assert -f verilog.f --top-module cpu_tb -o cpu_sim && \
./obj_dir/cpu_sim || exit 1
